// ==== dv/tb_control_unit.sv ====
module tb_control_unit;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 3000;
    // random cycles plus reset, idle and held-exception phases, with margin
    localparam int MAX_CYCLES   = 3100;

    logic clk_i;
    logic rstn_i;

    logic icache_miss_i, icache_ready_i;
    logic id_valid_i, id_csr_fence_i, id_is_branch_i, id_pred_branch_i, id_valid_jal_i;
    logic ir_valid_i, ir_is_branch_i, ir_full_iq_i, ir_empty_free_list_i, ir_out_of_chkp_i;
    logic rr_gl_full_i;
    logic exe_valid_i, exe_correct_pred_i, exe_stall_i;
    core_pkg::wb_mask_t  wb_valid_i, wb_we_i;
    logic wb_correct_pred_i, wb_chkp_done_i;
    core_pkg::chkp_t     wb_chkp_i;
    core_pkg::gl_index_t wb_gl_index_i;
    logic commit_valid_i, commit_xcpt_i, commit_ecall_i, commit_csr_fence_i;
    logic commit_fence_i, commit_fence_i_i, commit_we_i, commit_regfile_we_i;
    logic commit_stall_i;
    logic csr_exception_i, csr_eret_i, csr_stall_i;

    fetch_pkg::next_pc_sel_e    next_pc_sel_o;
    fetch_pkg::fetch_addr_sel_e fetch_addr_sel_o;
    logic invalidate_icache_o, invalidate_buffer_o;
    logic stall_if1_o, stall_if2_o, stall_id_o, stall_iq_o;
    logic stall_ir_o, stall_rr_o, stall_exe_o, stall_commit_o;
    logic flush_if_o, flush_id_o, flush_ir_o, flush_rr_o, flush_exe_o;
    logic do_checkpoint_o, do_recover_o, delete_checkpoint_o;
    core_pkg::chkp_t     recover_chkp_o;
    logic enable_commit_update_o, recover_commit_o, flush_gl_commit_o, enable_commit_o;
    core_pkg::wb_mask_t  rf_we_o;
    logic flush_gl_o;
    core_pkg::gl_index_t flush_gl_index_o;

    // model copies of the three registers and their next values
    logic m_xcpt, m_csr, m_fence;
    logic n_xcpt, n_csr, n_fence;
    int   cycle_count;

    control_unit dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $fatal(1);
        end
    end

    function automatic logic chance(input int n);
        return ($urandom % n) == 0;
    endfunction

    task automatic check_value(input string name, input logic [7:0] dut, input logic [7:0] exp);
        assert (dut === exp) else begin
            $display("Error %s dut %0h model %0h", name, dut, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        {icache_miss_i, id_valid_i, id_csr_fence_i, id_is_branch_i, id_pred_branch_i} = '0;
        {id_valid_jal_i, ir_valid_i, ir_is_branch_i, ir_full_iq_i} = '0;
        {ir_empty_free_list_i, ir_out_of_chkp_i, rr_gl_full_i} = '0;
        {exe_valid_i, exe_correct_pred_i, exe_stall_i} = '0;
        {wb_valid_i, wb_we_i, wb_correct_pred_i, wb_chkp_done_i, wb_chkp_i, wb_gl_index_i} = '0;
        {commit_valid_i, commit_xcpt_i, commit_ecall_i, commit_csr_fence_i} = '0;
        {commit_fence_i, commit_fence_i_i, commit_we_i, commit_regfile_we_i} = '0;
        {commit_stall_i, csr_exception_i, csr_eret_i, csr_stall_i} = '0;
        icache_ready_i = 1'b1;
    endtask

    task automatic drive_random();
        int xsel;
        // about one cycle in sixteen carries one of four exception sources
        xsel = $urandom % 64;
        commit_xcpt_i   = (xsel == 0);
        csr_exception_i = (xsel == 1);
        csr_eret_i      = (xsel == 2);
        commit_ecall_i  = (xsel == 3);
        csr_stall_i     = chance(8);
        icache_miss_i   = chance(8);
        icache_ready_i  = !chance(8);
        id_valid_i           = chance(2);
        id_csr_fence_i       = chance(8);
        id_is_branch_i       = chance(2);
        id_pred_branch_i     = chance(2);
        id_valid_jal_i       = chance(4);
        ir_valid_i           = chance(2);
        ir_is_branch_i       = chance(2);
        ir_full_iq_i         = chance(8);
        ir_empty_free_list_i = chance(4);
        ir_out_of_chkp_i     = chance(4);
        rr_gl_full_i         = chance(4);
        exe_valid_i          = chance(2);
        exe_correct_pred_i   = chance(2);
        exe_stall_i          = chance(4);
        wb_valid_i        = core_pkg::wb_mask_t'($urandom);
        wb_we_i           = core_pkg::wb_mask_t'($urandom);
        wb_correct_pred_i = chance(2);
        wb_chkp_done_i    = chance(2);
        wb_chkp_i         = core_pkg::chkp_t'($urandom);
        wb_gl_index_i     = core_pkg::gl_index_t'($urandom);
        commit_valid_i      = chance(2);
        commit_csr_fence_i  = chance(8);
        commit_fence_i      = chance(8);
        commit_fence_i_i    = chance(8);
        commit_we_i         = chance(2);
        commit_regfile_we_i = chance(2);
        commit_stall_i      = chance(8);
    endtask

    task automatic check_outputs();
        logic mis, xev, pulse, jump, keep, fe_all, bk_all, exe_mis, redir, cwrite, block;
        logic e_ir, e_fir, e_fclr;
        fetch_pkg::next_pc_sel_e    e_pc;
        fetch_pkg::fetch_addr_sel_e e_addr;
        core_pkg::wb_mask_t         e_we;
        mis = wb_valid_i[0] & ~wb_correct_pred_i;
        xev = (commit_valid_i & commit_xcpt_i) | csr_exception_i | csr_eret_i |
              (commit_valid_i & commit_ecall_i);
        pulse   = m_xcpt | m_csr;
        fe_all  = csr_stall_i | ir_full_iq_i;
        bk_all  = exe_stall_i | rr_gl_full_i;
        exe_mis = exe_valid_i & ~exe_correct_pred_i;
        jump = mis | (id_valid_i & id_pred_branch_i & ~id_is_branch_i) | id_valid_jal_i | pulse;
        keep = fe_all | (commit_valid_i & commit_csr_fence_i) | icache_miss_i |
               ~icache_ready_i | (id_valid_i & id_csr_fence_i) | m_fence |
               (commit_valid_i & commit_fence_i);
        e_pc = jump ? fetch_pkg::NEXT_PC_JUMP :
               keep ? fetch_pkg::NEXT_PC_KEEP : fetch_pkg::NEXT_PC_BP_OR_PC4;
        e_addr = m_xcpt ? fetch_pkg::ADDR_CSR : m_csr ? fetch_pkg::ADDR_CSR_RW :
                 mis ? fetch_pkg::ADDR_EXECUTION : fetch_pkg::ADDR_DECODE;
        redir = ~csr_stall_i & (id_csr_fence_i | m_fence | commit_csr_fence_i |
                id_valid_jal_i | (commit_valid_i & commit_fence_i) |
                (id_valid_i & id_pred_branch_i & ~id_is_branch_i));
        e_ir   = csr_stall_i | bk_all | ir_empty_free_list_i;
        e_fclr = m_xcpt | mis | exe_mis;
        e_fir  = e_fclr;
        cwrite = commit_valid_i & ~commit_xcpt_i & ~csr_exception_i & commit_we_i;
        e_we   = (wb_valid_i & wb_we_i) | {1'b0, cwrite};
        block  = (~m_xcpt & xev) | commit_stall_i;

        check_value("next_pc_sel_o", 8'(next_pc_sel_o), 8'(e_pc));
        check_value("fetch_addr_sel_o", 8'(fetch_addr_sel_o), 8'(e_addr));
        check_value("invalidate_icache_o", 8'(invalidate_icache_o),
                    8'(commit_valid_i & commit_fence_i_i));
        check_value("invalidate_buffer_o", 8'(invalidate_buffer_o), 8'(commit_valid_i &
                    (commit_fence_i_i | m_xcpt | (commit_csr_fence_i & ~commit_fence_i))));
        check_value("stall_if1_o", 8'(stall_if1_o), 8'(fe_all | icache_miss_i |
                    !icache_ready_i | (commit_valid_i & commit_csr_fence_i)));
        check_value("stall_if2_o", 8'(stall_if2_o), 8'(fe_all));
        check_value("stall_id_o", 8'(stall_id_o), 8'(fe_all));
        check_value("stall_iq_o", 8'(stall_iq_o), 8'(csr_stall_i | bk_all |
                    (~ir_empty_free_list_i & ir_out_of_chkp_i)));
        check_value("stall_ir_o", 8'(stall_ir_o), 8'(e_ir));
        check_value("stall_rr_o", 8'(stall_rr_o), 8'(csr_stall_i | bk_all));
        check_value("stall_exe_o", 8'(stall_exe_o), 8'(csr_stall_i));
        check_value("stall_commit_o", 8'(stall_commit_o), 8'(commit_stall_i));
        check_value("flush_if_o", 8'(flush_if_o), 8'(pulse | mis | redir));
        check_value("flush_id_o", 8'(flush_id_o), 8'(pulse | mis));
        check_value("flush_ir_o", 8'(flush_ir_o), 8'(e_fir));
        check_value("flush_rr_o", 8'(flush_rr_o), 8'(m_xcpt | mis |
                    (~exe_stall_i & (exe_mis | rr_gl_full_i))));
        check_value("flush_exe_o", 8'(flush_exe_o), 8'(m_xcpt));
        check_value("do_checkpoint_o", 8'(do_checkpoint_o), 8'(ir_valid_i & ir_is_branch_i &
                    ~ir_out_of_chkp_i & ~e_fir & ~e_ir));
        check_value("do_recover_o", 8'(do_recover_o), 8'(mis & wb_chkp_done_i));
        check_value("delete_checkpoint_o", 8'(delete_checkpoint_o),
                    8'(wb_valid_i[0] & wb_correct_pred_i & wb_chkp_done_i));
        check_value("recover_chkp_o", 8'(recover_chkp_o), 8'(wb_chkp_i));
        check_value("enable_commit_update_o", 8'(enable_commit_update_o),
                    8'(commit_valid_i & commit_regfile_we_i & ~block));
        check_value("enable_commit_o", 8'(enable_commit_o), 8'(!block));
        check_value("recover_commit_o", 8'(recover_commit_o), 8'(m_xcpt));
        check_value("flush_gl_commit_o", 8'(flush_gl_commit_o), 8'(m_xcpt));
        check_value("rf_we_o", 8'(rf_we_o), 8'(e_we));
        check_value("flush_gl_o", 8'(flush_gl_o), 8'(mis));
        check_value("flush_gl_index_o", 8'(flush_gl_index_o), mis ? 8'(wb_gl_index_i) : 8'h00);

        // register updates that the coming edge will take
        n_xcpt = ~m_xcpt & xev;
        n_csr  = ~m_csr & commit_valid_i & commit_csr_fence_i & ~xev;
        if (e_fclr) begin
            n_fence = 1'b0;
        end else if (id_valid_i && id_csr_fence_i) begin
            n_fence = 1'b1;
        end else if (commit_valid_i && commit_csr_fence_i) begin
            n_fence = 1'b0;
        end else begin
            n_fence = m_fence;
        end
    endtask

    // mode 0 idle, 1 held eret, 2 random
    task automatic step(input int mode);
        @(posedge clk_i);
        m_xcpt  = n_xcpt;
        m_csr   = n_csr;
        m_fence = n_fence;
        #2;
        drive_idle();
        if (mode == 1) begin
            csr_eret_i = 1'b1;
        end else if (mode == 2) begin
            drive_random();
        end
        #(CLK_PERIOD - 3);
        check_outputs();
    endtask

    initial begin
        void'($urandom(32'hf68421be));
        cycle_count = 0;
        {m_xcpt, m_csr, m_fence} = '0;
        {n_xcpt, n_csr, n_fence} = '0;
        rstn_i = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2 rstn_i = 1'b1;
        repeat (4) step(0);
        // a persistent trap source toggles the redirect pulse
        repeat (6) step(1);
        repeat (RAND_CYCLES) step(2);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== logic/control_unit.sv ====
module control_unit (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       icache_miss_i,
    input  logic                       icache_ready_i,

    input  logic                       id_valid_i,
    input  logic                       id_csr_fence_i,
    input  logic                       id_is_branch_i,
    input  logic                       id_pred_branch_i,
    input  logic                       id_valid_jal_i,

    input  logic                       ir_valid_i,
    input  logic                       ir_is_branch_i,
    input  logic                       ir_full_iq_i,
    input  logic                       ir_empty_free_list_i,
    input  logic                       ir_out_of_chkp_i,
    input  logic                       rr_gl_full_i,

    input  logic                       exe_valid_i,
    input  logic                       exe_correct_pred_i,
    input  logic                       exe_stall_i,

    input  core_pkg::wb_mask_t         wb_valid_i,
    input  core_pkg::wb_mask_t         wb_we_i,
    input  logic                       wb_correct_pred_i,
    input  logic                       wb_chkp_done_i,
    input  core_pkg::chkp_t            wb_chkp_i,
    input  core_pkg::gl_index_t        wb_gl_index_i,

    input  logic                       commit_valid_i,
    input  logic                       commit_xcpt_i,
    input  logic                       commit_ecall_i,
    input  logic                       commit_csr_fence_i,
    input  logic                       commit_fence_i,
    input  logic                       commit_fence_i_i,
    input  logic                       commit_we_i,
    input  logic                       commit_regfile_we_i,
    input  logic                       commit_stall_i,

    input  logic                       csr_exception_i,
    input  logic                       csr_eret_i,
    input  logic                       csr_stall_i,

    output fetch_pkg::next_pc_sel_e    next_pc_sel_o,
    output fetch_pkg::fetch_addr_sel_e fetch_addr_sel_o,
    output logic                       invalidate_icache_o,
    output logic                       invalidate_buffer_o,

    output logic                       stall_if1_o,
    output logic                       stall_if2_o,
    output logic                       stall_id_o,
    output logic                       stall_iq_o,
    output logic                       stall_ir_o,
    output logic                       stall_rr_o,
    output logic                       stall_exe_o,
    output logic                       stall_commit_o,
    output logic                       flush_if_o,
    output logic                       flush_id_o,
    output logic                       flush_ir_o,
    output logic                       flush_rr_o,
    output logic                       flush_exe_o,

    output logic                       do_checkpoint_o,
    output logic                       do_recover_o,
    output logic                       delete_checkpoint_o,
    output core_pkg::chkp_t            recover_chkp_o,
    output logic                       enable_commit_update_o,
    output logic                       recover_commit_o,
    output logic                       flush_gl_commit_o,
    output logic                       enable_commit_o,
    output core_pkg::wb_mask_t         rf_we_o,
    output logic                       flush_gl_o,
    output core_pkg::gl_index_t        flush_gl_index_o
);

    logic mispredict_wb;
    logic xcpt_active;
    logic csr_redirect_active;
    logic xcpt_next;
    logic fence_inflight;
    logic fence_clear;

    redirect_unit redirect0 (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .commit_valid_i        (commit_valid_i),
        .commit_xcpt_i         (commit_xcpt_i),
        .commit_ecall_i        (commit_ecall_i),
        .commit_csr_fence_i    (commit_csr_fence_i),
        .commit_fence_i        (commit_fence_i),
        .commit_fence_i_i      (commit_fence_i_i),
        .csr_exception_i       (csr_exception_i),
        .csr_eret_i            (csr_eret_i),
        .id_valid_i            (id_valid_i),
        .id_csr_fence_i        (id_csr_fence_i),
        .id_is_branch_i        (id_is_branch_i),
        .id_pred_branch_i      (id_pred_branch_i),
        .id_valid_jal_i        (id_valid_jal_i),
        // branches resolve on writeback port 0 only
        .wb_valid0_i           (wb_valid_i[0]),
        .wb_correct_pred_i     (wb_correct_pred_i),
        .stall_if1_i           (stall_if1_o),
        .fence_clear_i         (fence_clear),
        .mispredict_wb_o       (mispredict_wb),
        .xcpt_active_o         (xcpt_active),
        .csr_redirect_active_o (csr_redirect_active),
        .xcpt_next_o           (xcpt_next),
        .fence_inflight_o      (fence_inflight),
        .next_pc_sel_o         (next_pc_sel_o),
        .fetch_addr_sel_o      (fetch_addr_sel_o),
        .invalidate_icache_o   (invalidate_icache_o),
        .invalidate_buffer_o   (invalidate_buffer_o)
    );

    hazard_unit hazard0 (
        .mispredict_wb_i       (mispredict_wb),
        .xcpt_active_i         (xcpt_active),
        .csr_redirect_active_i (csr_redirect_active),
        .fence_inflight_i      (fence_inflight),
        .exe_valid_i           (exe_valid_i),
        .exe_correct_pred_i    (exe_correct_pred_i),
        .exe_stall_i           (exe_stall_i),
        .rr_gl_full_i          (rr_gl_full_i),
        .ir_full_iq_i          (ir_full_iq_i),
        .ir_empty_free_list_i  (ir_empty_free_list_i),
        .ir_out_of_chkp_i      (ir_out_of_chkp_i),
        .csr_stall_i           (csr_stall_i),
        .id_valid_i            (id_valid_i),
        .id_csr_fence_i        (id_csr_fence_i),
        .id_valid_jal_i        (id_valid_jal_i),
        .id_is_branch_i        (id_is_branch_i),
        .id_pred_branch_i      (id_pred_branch_i),
        .commit_valid_i        (commit_valid_i),
        .commit_csr_fence_i    (commit_csr_fence_i),
        .commit_fence_i        (commit_fence_i),
        .commit_stall_i        (commit_stall_i),
        .icache_miss_i         (icache_miss_i),
        .icache_ready_i        (icache_ready_i),
        .stall_if1_o           (stall_if1_o),
        .stall_if2_o           (stall_if2_o),
        .stall_id_o            (stall_id_o),
        .stall_iq_o            (stall_iq_o),
        .stall_ir_o            (stall_ir_o),
        .stall_rr_o            (stall_rr_o),
        .stall_exe_o           (stall_exe_o),
        .stall_commit_o        (stall_commit_o),
        .flush_if_o            (flush_if_o),
        .flush_id_o            (flush_id_o),
        .flush_ir_o            (flush_ir_o),
        .flush_rr_o            (flush_rr_o),
        .flush_exe_o           (flush_exe_o),
        .fence_clear_o         (fence_clear)
    );

    rename_commit_ctrl rename_commit0 (
        .mispredict_wb_i        (mispredict_wb),
        .xcpt_active_i          (xcpt_active),
        .xcpt_next_i            (xcpt_next),
        .flush_ir_i             (flush_ir_o),
        .stall_ir_i             (stall_ir_o),
        .ir_valid_i             (ir_valid_i),
        .ir_is_branch_i         (ir_is_branch_i),
        .ir_out_of_chkp_i       (ir_out_of_chkp_i),
        .wb_valid_i             (wb_valid_i),
        .wb_we_i                (wb_we_i),
        .wb_correct_pred_i      (wb_correct_pred_i),
        .wb_chkp_done_i         (wb_chkp_done_i),
        .wb_chkp_i              (wb_chkp_i),
        .wb_gl_index_i          (wb_gl_index_i),
        .commit_valid_i         (commit_valid_i),
        .commit_xcpt_i          (commit_xcpt_i),
        .commit_we_i            (commit_we_i),
        .commit_regfile_we_i    (commit_regfile_we_i),
        .commit_stall_i         (commit_stall_i),
        .csr_exception_i        (csr_exception_i),
        .do_checkpoint_o        (do_checkpoint_o),
        .do_recover_o           (do_recover_o),
        .delete_checkpoint_o    (delete_checkpoint_o),
        .recover_chkp_o         (recover_chkp_o),
        .enable_commit_update_o (enable_commit_update_o),
        .recover_commit_o       (recover_commit_o),
        .flush_gl_commit_o      (flush_gl_commit_o),
        .enable_commit_o        (enable_commit_o),
        .rf_we_o                (rf_we_o),
        .flush_gl_o             (flush_gl_o),
        .flush_gl_index_o       (flush_gl_index_o)
    );

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

    // scalar writeback ports into the register file
    localparam int NUM_SCALAR_WB = 2;

    // graduation list holds 64 entries
    localparam int GL_INDEX_W = 6;

    // four rename checkpoints
    localparam int CHKP_W = 2;

    typedef logic [GL_INDEX_W-1:0] gl_index_t;

    typedef logic [CHKP_W-1:0] chkp_t;

    // one bit per scalar writeback port
    typedef logic [NUM_SCALAR_WB-1:0] wb_mask_t;

endpackage

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    // where fetch takes its next pc from
    typedef enum logic [1:0] {
        NEXT_PC_BP_OR_PC4 = 2'd0,
        NEXT_PC_KEEP      = 2'd1,
        NEXT_PC_JUMP      = 2'd2
    } next_pc_sel_e;

    // which stage supplies the redirect address
    typedef enum logic [1:0] {
        ADDR_DECODE    = 2'd0,
        ADDR_EXECUTION = 2'd1,
        ADDR_CSR       = 2'd2,
        ADDR_CSR_RW    = 2'd3
    } fetch_addr_sel_e;

endpackage

// ==== logic/hazard_unit.sv ====
module hazard_unit (
    input  logic mispredict_wb_i,
    input  logic xcpt_active_i,
    input  logic csr_redirect_active_i,
    input  logic fence_inflight_i,

    input  logic exe_valid_i,
    input  logic exe_correct_pred_i,
    input  logic exe_stall_i,
    input  logic rr_gl_full_i,
    input  logic ir_full_iq_i,
    input  logic ir_empty_free_list_i,
    input  logic ir_out_of_chkp_i,
    input  logic csr_stall_i,

    input  logic id_valid_i,
    input  logic id_csr_fence_i,
    input  logic id_valid_jal_i,
    input  logic id_is_branch_i,
    input  logic id_pred_branch_i,

    input  logic commit_valid_i,
    input  logic commit_csr_fence_i,
    input  logic commit_fence_i,
    input  logic commit_stall_i,

    input  logic icache_miss_i,
    input  logic icache_ready_i,

    output logic stall_if1_o,
    output logic stall_if2_o,
    output logic stall_id_o,
    output logic stall_iq_o,
    output logic stall_ir_o,
    output logic stall_rr_o,
    output logic stall_exe_o,
    output logic stall_commit_o,
    output logic flush_if_o,
    output logic flush_id_o,
    output logic flush_ir_o,
    output logic flush_rr_o,
    output logic flush_exe_o,
    output logic fence_clear_o
);

    logic exe_mispredict;
    logic if1_redirect;

    assign exe_mispredict = exe_valid_i & ~exe_correct_pred_i;

    // decode-side reasons to drop the instruction in if1
    assign if1_redirect = id_csr_fence_i | fence_inflight_i | commit_csr_fence_i |
                          id_valid_jal_i |
                          (commit_valid_i & commit_fence_i) |
                          (id_valid_i & ~id_is_branch_i & id_pred_branch_i);

    always_comb begin
        stall_if1_o = 1'b0;
        stall_if2_o = 1'b0;
        stall_id_o  = 1'b0;
        if (csr_stall_i || ir_full_iq_i) begin
            stall_if1_o = 1'b1;
            stall_if2_o = 1'b1;
            stall_id_o  = 1'b1;
        end else if ((commit_valid_i && commit_csr_fence_i) || icache_miss_i || !icache_ready_i) begin
            stall_if1_o = 1'b1;
        end
    end

    always_comb begin
        stall_iq_o  = 1'b0;
        stall_ir_o  = 1'b0;
        stall_rr_o  = 1'b0;
        stall_exe_o = 1'b0;
        if (csr_stall_i) begin
            stall_iq_o  = 1'b1;
            stall_ir_o  = 1'b1;
            stall_rr_o  = 1'b1;
            stall_exe_o = 1'b1;
        end else if (exe_stall_i || rr_gl_full_i) begin
            stall_iq_o = 1'b1;
            stall_ir_o = 1'b1;
            stall_rr_o = 1'b1;
        end else if (ir_empty_free_list_i) begin
            stall_ir_o = 1'b1;
        end else if (ir_out_of_chkp_i) begin
            stall_iq_o = 1'b1;
        end
    end

    assign stall_commit_o = commit_stall_i;

    always_comb begin
        flush_if_o = 1'b0;
        flush_id_o = 1'b0;
        if (xcpt_active_i || csr_redirect_active_i || mispredict_wb_i) begin
            flush_if_o = 1'b1;
            flush_id_o = 1'b1;
        end else if (if1_redirect && !csr_stall_i) begin
            flush_if_o = 1'b1;
        end
    end

    // any backend flush also discards a pending fence
    always_comb begin
        flush_ir_o    = 1'b0;
        flush_rr_o    = 1'b0;
        flush_exe_o   = 1'b0;
        fence_clear_o = 1'b0;
        if (xcpt_active_i) begin
            flush_ir_o    = 1'b1;
            flush_rr_o    = 1'b1;
            flush_exe_o   = 1'b1;
            fence_clear_o = 1'b1;
        end else if (mispredict_wb_i) begin
            flush_ir_o    = 1'b1;
            flush_rr_o    = 1'b1;
            fence_clear_o = 1'b1;
        end else if (exe_mispredict) begin
            flush_ir_o    = 1'b1;
            flush_rr_o    = ~exe_stall_i;
            fence_clear_o = 1'b1;
        end else if (rr_gl_full_i && !exe_stall_i) begin
            // bubble into exe while rr holds
            flush_rr_o = 1'b1;
        end
    end

endmodule

// ==== logic/redirect_unit.sv ====
module redirect_unit (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    input  logic                       commit_valid_i,
    input  logic                       commit_xcpt_i,
    input  logic                       commit_ecall_i,
    input  logic                       commit_csr_fence_i,
    input  logic                       commit_fence_i,
    input  logic                       commit_fence_i_i,
    input  logic                       csr_exception_i,
    input  logic                       csr_eret_i,

    input  logic                       id_valid_i,
    input  logic                       id_csr_fence_i,
    input  logic                       id_is_branch_i,
    input  logic                       id_pred_branch_i,
    input  logic                       id_valid_jal_i,

    input  logic                       wb_valid0_i,
    input  logic                       wb_correct_pred_i,

    input  logic                       stall_if1_i,
    input  logic                       fence_clear_i,

    output logic                       mispredict_wb_o,
    output logic                       xcpt_active_o,
    output logic                       csr_redirect_active_o,
    output logic                       xcpt_next_o,
    output logic                       fence_inflight_o,
    output fetch_pkg::next_pc_sel_e    next_pc_sel_o,
    output fetch_pkg::fetch_addr_sel_e fetch_addr_sel_o,
    output logic                       invalidate_icache_o,
    output logic                       invalidate_buffer_o
);

    logic xcpt_event;
    logic csr_event;
    logic csr_next;
    logic jump;

    // anything that sends fetch to the trap vector or back from a trap
    assign xcpt_event = (commit_valid_i & commit_xcpt_i) |
                        csr_exception_i |
                        csr_eret_i |
                        (commit_valid_i & commit_ecall_i);

    assign csr_event = commit_valid_i & commit_csr_fence_i;

    // pulses drop for a cycle after firing, so a held event toggles
    assign xcpt_next_o = ~xcpt_active_o & xcpt_event;
    assign csr_next    = ~csr_redirect_active_o & csr_event & ~xcpt_event;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_active_o         <= 1'b0;
            csr_redirect_active_o <= 1'b0;
        end else begin
            xcpt_active_o         <= xcpt_next_o;
            csr_redirect_active_o <= csr_next;
        end
    end

    // a csr or fence is somewhere between decode and commit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_inflight_o <= 1'b0;
        end else if (fence_clear_i) begin
            fence_inflight_o <= 1'b0;
        end else if (id_valid_i & id_csr_fence_i) begin
            fence_inflight_o <= 1'b1;
        end else if (commit_valid_i & commit_csr_fence_i) begin
            fence_inflight_o <= 1'b0;
        end
    end

    assign mispredict_wb_o = wb_valid0_i & ~wb_correct_pred_i;

    // wrong taken prediction on a non-branch, a jal, or a resolved branch
    assign jump = mispredict_wb_o |
                  (id_valid_i & ~id_is_branch_i & id_pred_branch_i) |
                  id_valid_jal_i |
                  xcpt_active_o |
                  csr_redirect_active_o;

    always_comb begin
        if (jump) begin
            next_pc_sel_o = fetch_pkg::NEXT_PC_JUMP;
        end else if (stall_if1_i || (id_valid_i && id_csr_fence_i) || fence_inflight_o ||
                     (commit_valid_i && commit_fence_i)) begin
            next_pc_sel_o = fetch_pkg::NEXT_PC_KEEP;
        end else begin
            next_pc_sel_o = fetch_pkg::NEXT_PC_BP_OR_PC4;
        end
    end

    always_comb begin
        if (xcpt_active_o) begin
            fetch_addr_sel_o = fetch_pkg::ADDR_CSR;
        end else if (csr_redirect_active_o) begin
            fetch_addr_sel_o = fetch_pkg::ADDR_CSR_RW;
        end else if (mispredict_wb_o) begin
            fetch_addr_sel_o = fetch_pkg::ADDR_EXECUTION;
        end else begin
            fetch_addr_sel_o = fetch_pkg::ADDR_DECODE;
        end
    end

    // fence.i may follow self-modifying stores
    assign invalidate_icache_o = commit_valid_i & commit_fence_i_i;

    // refetch after fence.i, trap entry or a csr write
    assign invalidate_buffer_o = commit_valid_i &
                                 (commit_fence_i_i | xcpt_active_o |
                                  (commit_csr_fence_i & ~commit_fence_i));

endmodule

// ==== logic/rename_commit_ctrl.sv ====
module rename_commit_ctrl (
    input  logic                mispredict_wb_i,
    input  logic                xcpt_active_i,
    input  logic                xcpt_next_i,
    input  logic                flush_ir_i,
    input  logic                stall_ir_i,

    input  logic                ir_valid_i,
    input  logic                ir_is_branch_i,
    input  logic                ir_out_of_chkp_i,

    input  core_pkg::wb_mask_t  wb_valid_i,
    input  core_pkg::wb_mask_t  wb_we_i,
    input  logic                wb_correct_pred_i,
    input  logic                wb_chkp_done_i,
    input  core_pkg::chkp_t     wb_chkp_i,
    input  core_pkg::gl_index_t wb_gl_index_i,

    input  logic                commit_valid_i,
    input  logic                commit_xcpt_i,
    input  logic                commit_we_i,
    input  logic                commit_regfile_we_i,
    input  logic                commit_stall_i,
    input  logic                csr_exception_i,

    output logic                do_checkpoint_o,
    output logic                do_recover_o,
    output logic                delete_checkpoint_o,
    output core_pkg::chkp_t     recover_chkp_o,
    output logic                enable_commit_update_o,
    output logic                recover_commit_o,
    output logic                flush_gl_commit_o,
    output logic                enable_commit_o,
    output core_pkg::wb_mask_t  rf_we_o,
    output logic                flush_gl_o,
    output core_pkg::gl_index_t flush_gl_index_o
);

    logic commit_write;
    logic commit_block;

    // snapshot rename state on every branch that actually enters rename
    assign do_checkpoint_o = ir_valid_i & ir_is_branch_i & ~ir_out_of_chkp_i &
                             ~flush_ir_i & ~stall_ir_i;

    assign do_recover_o        = mispredict_wb_i & wb_chkp_done_i;
    assign delete_checkpoint_o = wb_valid_i[0] & wb_correct_pred_i & wb_chkp_done_i;
    assign recover_chkp_o      = wb_chkp_i;

    // port 0 is shared with the commit write path
    assign commit_write = commit_valid_i & ~commit_xcpt_i & ~csr_exception_i & commit_we_i;

    always_comb begin
        for (int i = 0; i < core_pkg::NUM_SCALAR_WB; i++) begin
            rf_we_o[i] = wb_valid_i[i] & wb_we_i[i];
        end
        rf_we_o[0] = rf_we_o[0] | commit_write;
    end

    // hold commit while a trap is about to redirect
    assign commit_block = xcpt_next_i | commit_stall_i;

    assign enable_commit_update_o = commit_valid_i & commit_regfile_we_i & ~commit_block;
    assign enable_commit_o        = ~commit_block;

    assign recover_commit_o  = xcpt_active_i;
    assign flush_gl_commit_o = xcpt_active_i;

    assign flush_gl_o       = mispredict_wb_i;
    assign flush_gl_index_o = mispredict_wb_i ? wb_gl_index_i : '0;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_control_unit \
    -Mdir obj_dir -o tb_sim || { echo "build failed"; exit 1; }
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "sim passed" && echo "PASS" || {
    echo "FAIL"
    exit 1
}

// ==== vlog.f ====
logic/core_pkg.sv
logic/fetch_pkg.sv
logic/redirect_unit.sv
logic/hazard_unit.sv
logic/rename_commit_ctrl.sv
logic/control_unit.sv
dv/tb_control_unit.sv
